// ==== compression_host.f ====
hw/comp_pkg.sv
hw/host_if_pkg.sv
hw/byte_buffer.sv
hw/lz_dictionary.sv
hw/compression_engine.sv
hw/compression_host.sv
verif/tb_clock_gen.sv
verif/compression_checker.sv
verif/compression_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the compression host testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module compression_tb -f compression_host.f --Mdir obj_dir; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vcompression_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== verif/compression_tb.sv ====
//////////////////////////////////////////////////////////////////////
// 200 seeded random jobs with a full output readback after each
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module compression_tb
    import comp_pkg::*;
    import host_if_pkg::*;
();

    localparam logic [PATTERN_W-1:0] PATTERN = 56'h12_3456_789A_BCDE;
    localparam int                   NUM_JOBS = 200;

    logic                  clk;
    logic                  rst;
    load_req_t             load;
    logic                  start;
    comp_mode_e            mode;
    logic [BUF_ADDR_W-1:0] rd_addr;
    logic [7:0]            rd_data;
    logic                  busy;
    comp_result_t          result;
    logic                  rd_check;
    int                    errors;
    int                    checks;
    bit                    timed_out;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    compression_host #(.PATTERN(PATTERN)) DUT (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .start   (start),
        .mode    (mode),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .busy    (busy),
        .result  (result)
    );

    compression_checker #(.PATTERN(PATTERN)) u_checker (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .start    (start),
        .mode     (mode),
        .busy     (busy),
        .result   (result),
        .rd_check (rd_check),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .errors   (errors),
        .checks   (checks)
    );

    // Repeats and small values keep runs, hits and short codes frequent
    function automatic logic [7:0] pick_byte(input logic [7:0] prev, input bit same);
        int unsigned r;
        r = $urandom_range(7, 0);
        if (same || r < 3) return prev;
        if (r < 5) return 8'($urandom_range(15, 0));
        if (r == 5) return PATTERN[15:8] ^ 8'($urandom_range(15, 0));   // Seed entries
        return 8'($urandom);
    endfunction

    task automatic run_job(input int idx);
        int         len;
        int         n;
        int         wait_cnt;
        comp_mode_e m;
        logic [7:0] b;
        bit         same;
        len  = $urandom_range(34, 0);   // Up to two loads past the store size
        m    = comp_mode_e'(2'($urandom_range(3, 0)));
        same = 1'b0;
        if (idx % 10 == 5) begin   // Long dictionary job that mostly overflows
            m   = MODE_DICT;
            len = 34;
        end else if (idx % 10 == 7) begin   // One value in runs of 15, 15 and 2
            m    = MODE_RLE;
            len  = 32;
            same = 1'b1;
        end
        b = 8'($urandom);
        for (int i = 0; i < len; i++) begin
            b = pick_byte(b, same);
            @(posedge clk);
            load <= '{valid: 1'b1, data: b};
        end
        @(posedge clk);
        load  <= '0;
        start <= 1'b1;
        mode  <= m;
        @(posedge clk);
        mode <= (m == MODE_RLE) ? MODE_SCRAMBLE : MODE_RLE;   // Second start while busy
        @(posedge clk);
        start <= 1'b0;
        load  <= '{valid: 1'b1, data: 8'hA5};   // Load while busy
        wait_cnt = 0;
        do begin
            @(posedge clk);
            load <= '0;
            wait_cnt++;
        end while (!result.done && wait_cnt < 100);
        if (!result.done) begin
            $display("Job %0d never signalled done", idx);
            timed_out = 1'b1;
            return;
        end
        n = (result.out_len > 6'd32) ? 32 : int'(result.out_len);
        for (int a = 0; a < n; a++) begin
            @(posedge clk);
            rd_addr  <= 5'(a);
            rd_check <= 1'b1;
        end
        @(posedge clk);
        rd_check <= 1'b0;
    endtask

    initial begin
        int wait_cnt;
        void'($urandom(80734));
        load      = '0;
        start     = 1'b0;
        mode      = MODE_RLE;
        rd_addr   = '0;
        rd_check  = 1'b0;
        timed_out = 1'b0;
        wait_cnt  = 0;
        while (rst !== 1'b0 && wait_cnt < 50) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst !== 1'b0) begin
            $display("Reset was never released");
            timed_out = 1'b1;
        end
        for (int j = 0; j < NUM_JOBS && !timed_out; j++) begin
            run_job(j);
        end
        repeat (3) @(posedge clk);
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verif/compression_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Snoops the host ports and predicts results from its own job model
// Dictionary and scramble pattern persist across jobs like the DUT
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module compression_checker
    import comp_pkg::*;
    import host_if_pkg::*;
#(
    parameter logic [PATTERN_W-1:0] PATTERN = RESET_PATTERN
) (
    input  logic                  clk,
    input  logic                  rst,
    input  load_req_t             load,
    input  logic                  start,
    input  comp_mode_e            mode,
    input  logic                  busy,
    input  comp_result_t          result,
    input  logic                  rd_check,   // rd_data is valid for comparison
    input  logic [BUF_ADDR_W-1:0] rd_addr,
    input  logic [7:0]            rd_data,
    output int                    errors,
    output int                    checks
);

    logic [7:0]           in_bytes [BUF_DEPTH];
    int                   in_cnt;
    logic [7:0]           dict [DICT_DEPTH];
    int                   dict_ptr;
    logic [PATTERN_W-1:0] pat;
    logic [7:0]           exp_out [64];
    int                   exp_len;        // Unsaturated output count
    logic                 exp_busy;

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("Error %s: got 0x%h expected 0x%h", name, got, expv);
        end
    endtask

    task automatic emit(input logic [7:0] b);
        if (exp_len < 64) begin
            exp_out[exp_len] = b;
        end
        exp_len++;
    endtask

    task automatic build_expected(input comp_mode_e m);
        int         i;
        int         k;
        int         off;
        logic [7:0] v;
        exp_len  = 0;
        dict_ptr = 0;   // Replacement restarts at slot 0 on every job
        i        = 0;
        while (i < in_cnt) begin
            v = in_bytes[i];
            k = 1;
            case (m)
                MODE_RLE: begin
                    while (i + k < in_cnt && in_bytes[i + k] == v && k < 15) k++;
                    if (k > 1) emit(8'(k));
                    emit(v);
                end
                MODE_DICT: begin
                    off = -1;
                    for (int e = 0; e < DICT_DEPTH; e++) begin
                        if (dict[e] == v) off = e;   // Last match has priority
                    end
                    if (off >= 0) begin
                        emit(8'(off));
                        emit(8'h01);
                    end else begin
                        emit(v);
                        dict[dict_ptr] = v;
                        dict_ptr       = (dict_ptr + 1) % DICT_DEPTH;
                    end
                end
                MODE_SHORT: emit((v < 8'h10) ? (8'h10 | v) : v);
                default: begin
                    emit(v ^ pat[7:0]);
                    pat = {pat[PATTERN_W-2:0], pat[PATTERN_W-1]};
                end
            endcase
            i += k;
        end
    endtask

    always @(posedge clk) begin
        logic idle_now;
        if (rst) begin
            in_cnt   = 0;
            exp_len  = 0;
            exp_busy = 1'b0;
            pat      = PATTERN;
            for (int e = 0; e < DICT_DEPTH; e++) begin
                dict[e] = PATTERN[15:8] ^ 8'(e);
            end
        end else begin
            idle_now = !exp_busy;
            compare("busy", {7'b0, busy}, {7'b0, exp_busy});
            if (result.done && !exp_busy) begin
                errors++;
                $display("done pulsed while no job was running");
            end else if (result.done) begin
                compare("out_len", {2'b00, result.out_len}, 8'((exp_len > 63) ? 63 : exp_len));
                compare("overflow", {7'b0, result.overflow}, {7'b0, exp_len > 32});
                compare("first_byte", result.first_byte, (exp_len > 0) ? exp_out[0] : 8'h00);
                exp_busy = 1'b0;
                in_cnt   = 0;
            end
            if (idle_now && load.valid && in_cnt < BUF_DEPTH) begin
                in_bytes[in_cnt] = load.data;
                in_cnt++;
            end
            if (idle_now && start && !load.valid) begin
                build_expected(mode);
                exp_busy = 1'b1;
            end
            if (rd_check) begin
                compare($sformatf("rd_data[%0d]", rd_addr), rd_data, exp_out[rd_addr]);
            end
        end
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
//////////////////////////////////////////////////////////////////////
// 10 ns clock, reset held high for the first 10 rising edges
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;   // Released on an edge like any other input
    end

endmodule

// ==== hw/compression_host.sv ====
//////////////////////////////////////////////////////////////////////
// Loads and starts are ignored while busy, there is no back-pressure
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module compression_host
    import comp_pkg::*;
    import host_if_pkg::*;
#(
    parameter logic [PATTERN_W-1:0] PATTERN = RESET_PATTERN
) (
    input  logic                  clk,
    input  logic                  rst,
    input  load_req_t             load,
    input  logic                  start,
    input  comp_mode_e            mode,
    input  logic [BUF_ADDR_W-1:0] rd_addr,
    output logic [7:0]            rd_data,
    output logic                  busy,
    output comp_result_t          result
);

    logic                  idle;
    logic                  in_wr_en;
    logic [BUF_ADDR_W-1:0] in_addr;    // Load position in idle, read pointer otherwise
    logic [7:0]            in_data;
    logic                  dict_hit;
    logic [3:0]            dict_offset;
    logic                  dict_clear;
    logic                  dict_insert;
    logic [7:0]            dict_byte;
    logic                  out_wr_en;
    logic [BUF_ADDR_W-1:0] out_wr_addr;
    logic [7:0]            out_wr_data;

    assign busy = !idle;

    byte_buffer u_in_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (in_wr_en),
        .wr_addr (in_addr),
        .wr_data (load.data),
        .rd_addr (in_addr),
        .rd_data (in_data)
    );

    byte_buffer u_out_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (out_wr_en),
        .wr_addr (out_wr_addr),
        .wr_data (out_wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    lz_dictionary #(.PATTERN(PATTERN)) u_dict (
        .clk         (clk),
        .rst         (rst),
        .clear_ptr   (dict_clear),
        .lookup_byte (dict_byte),
        .hit         (dict_hit),
        .hit_offset  (dict_offset),
        .insert      (dict_insert)
    );

    compression_engine #(.PATTERN(PATTERN)) u_engine (
        .clk          (clk),
        .rst          (rst),
        .idle         (idle),
        .in_wr_en     (in_wr_en),
        .start        (start),
        .mode         (mode),
        .in_count_inc (load.valid),
        .in_rd_addr   (in_addr),
        .in_rd_data   (in_data),
        .dict_hit     (dict_hit),
        .dict_offset  (dict_offset),
        .dict_clear   (dict_clear),
        .dict_insert  (dict_insert),
        .dict_byte    (dict_byte),
        .out_wr_en    (out_wr_en),
        .out_wr_addr  (out_wr_addr),
        .out_wr_data  (out_wr_data),
        .result       (result)
    );

endmodule

// ==== hw/compression_engine.sv ====
//////////////////////////////////////////////////////////////////////
// Job FSM, two cycles per input byte plus a flush and a report cycle
// Output past 32 bytes is counted but not stored
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module compression_engine
    import comp_pkg::*;
    import host_if_pkg::*;
#(
    parameter logic [PATTERN_W-1:0] PATTERN = RESET_PATTERN
) (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  idle,
    output logic                  in_wr_en,
    input  logic                  start,
    input  comp_mode_e            mode,
    input  logic                  in_count_inc,
    output logic [BUF_ADDR_W-1:0] in_rd_addr,
    input  logic [7:0]            in_rd_data,
    input  logic                  dict_hit,
    input  logic [3:0]            dict_offset,
    output logic                  dict_clear,
    output logic                  dict_insert,
    output logic [7:0]            dict_byte,
    output logic                  out_wr_en,
    output logic [BUF_ADDR_W-1:0] out_wr_addr,
    output logic [7:0]            out_wr_data,
    output comp_result_t          result
);

    engine_state_e        state;
    comp_mode_e           mode_q;
    logic [LEN_W-1:0]     in_count;
    logic [LEN_W-1:0]     rd_ptr;
    logic [LEN_W-1:0]     out_cnt;
    logic [7:0]           cur_byte;
    logic                 run_active;
    logic [3:0]           run_len;
    logic [7:0]           run_val;
    logic [LEN_W-1:0]     run_base;     // Position of the run's first byte
    logic                 pend_valid;   // Second byte waits for ANALYZE
    logic [LEN_W-1:0]     pend_pos;
    logic [7:0]           pend_data;
    logic [PATTERN_W-1:0] pattern;
    logic [7:0]           first_byte_q;
    logic                 start_ok;
    logic                 run_extend;
    logic                 wr_req;
    logic [LEN_W-1:0]     wr_pos;
    logic [7:0]           wr_data;

    function automatic logic [LEN_W-1:0] sat_inc(input logic [LEN_W-1:0] v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    assign idle       = (state == ST_IDLE);
    assign start_ok   = idle && start && !in_count_inc;   // Loads take priority
    assign in_wr_en   = idle && in_count_inc && (in_count < LEN_W'(BUF_DEPTH));
    assign in_rd_addr = idle ? in_count[BUF_ADDR_W-1:0] : rd_ptr[BUF_ADDR_W-1:0];

    assign dict_byte   = cur_byte;
    assign dict_clear  = start_ok;
    assign dict_insert = (state == ST_COMPRESS) && (mode_q == MODE_DICT) && !dict_hit;

    assign run_extend = run_active && (cur_byte == run_val) && (run_len != 4'd15);

    // One output write per cycle, ANALYZE only drains the pending byte
    always_comb begin
        wr_req  = 1'b0;
        wr_pos  = out_cnt;
        wr_data = cur_byte;
        if (state == ST_ANALYZE) begin
            wr_req  = pend_valid;
            wr_pos  = pend_pos;
            wr_data = pend_data;
        end else if (state == ST_COMPRESS) begin
            wr_req = 1'b1;
            case (mode_q)
                MODE_RLE: begin
                    if (run_extend) begin
                        wr_pos  = run_base;                 // Rewrite count in place
                        wr_data = {4'h0, run_len + 4'd1};
                    end
                end
                MODE_DICT: begin
                    if (dict_hit) begin
                        wr_data = {4'h0, dict_offset};
                    end
                end
                MODE_SHORT: begin
                    if (cur_byte[7:4] == 4'h0) begin
                        wr_data = {4'h1, cur_byte[3:0]};
                    end
                end
                MODE_SCRAMBLE: wr_data = cur_byte ^ pattern[7:0];
                default: wr_req = 1'b0;
            endcase
        end
    end

    assign out_wr_en   = wr_req && (wr_pos < LEN_W'(BUF_DEPTH));
    assign out_wr_addr = wr_pos[BUF_ADDR_W-1:0];
    assign out_wr_data = wr_data;

    always_comb begin
        result            = '0;
        result.done       = (state == ST_REPORT);
        result.overflow   = (out_cnt > LEN_W'(BUF_DEPTH));
        result.out_len    = out_cnt;
        result.first_byte = first_byte_q;   // Cleared at start, so zero if empty
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            mode_q       <= MODE_RLE;
            in_count     <= '0;
            rd_ptr       <= '0;
            out_cnt      <= '0;
            run_active   <= 1'b0;
            run_len      <= '0;
            pend_valid   <= 1'b0;
            pattern      <= PATTERN;
            first_byte_q <= '0;
        end else begin
            if (out_wr_en && (out_wr_addr == '0)) begin
                first_byte_q <= out_wr_data;
            end
            case (state)
                ST_IDLE: begin
                    if (in_wr_en) begin
                        in_count <= in_count + 1'b1;
                    end
                    if (start_ok) begin
                        mode_q       <= mode;
                        rd_ptr       <= '0;
                        out_cnt      <= '0;
                        run_active   <= 1'b0;
                        pend_valid   <= 1'b0;
                        first_byte_q <= '0;
                        state        <= ST_ANALYZE;
                    end
                end
                ST_ANALYZE: begin
                    pend_valid <= 1'b0;
                    state      <= (rd_ptr < in_count) ? ST_COMPRESS : ST_REPORT;
                end
                ST_COMPRESS: begin
                    rd_ptr <= rd_ptr + 1'b1;
                    state  <= ST_ANALYZE;
                    case (mode_q)
                        MODE_RLE: begin
                            if (run_extend) begin
                                run_len <= run_len + 4'd1;
                                if (run_len == 4'd1) begin   // Value moves behind count
                                    pend_valid <= 1'b1;
                                    out_cnt    <= sat_inc(out_cnt);
                                end
                            end else begin
                                run_active <= 1'b1;
                                run_len    <= 4'd1;
                                out_cnt    <= sat_inc(out_cnt);
                            end
                        end
                        MODE_DICT: begin
                            if (dict_hit) begin
                                pend_valid <= 1'b1;
                                out_cnt    <= sat_inc(sat_inc(out_cnt));
                            end else begin
                                out_cnt <= sat_inc(out_cnt);
                            end
                        end
                        MODE_SHORT: out_cnt <= sat_inc(out_cnt);
                        MODE_SCRAMBLE: begin
                            out_cnt <= sat_inc(out_cnt);
                            pattern <= {pattern[PATTERN_W-2:0], pattern[PATTERN_W-1]};
                        end
                        default: state <= ST_ANALYZE;
                    endcase
                end
                ST_REPORT: begin
                    in_count <= '0;
                    state    <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Byte and run payload
    always_ff @(posedge clk) begin
        if (state == ST_ANALYZE) begin
            cur_byte <= in_rd_data;
        end
        if (state == ST_COMPRESS) begin
            if (mode_q == MODE_RLE) begin
                if (!run_extend) begin
                    run_val  <= cur_byte;
                    run_base <= out_cnt;
                end else if (run_len == 4'd1) begin
                    pend_pos  <= out_cnt;
                    pend_data <= run_val;
                end
            end else if (mode_q == MODE_DICT && dict_hit) begin
                pend_pos  <= sat_inc(out_cnt);
                pend_data <= 8'h01;             // Match length is always one
            end
        end
    end

    // Output store must stay stable between jobs for host readback
    a_no_write_idle: assert property (
        @(posedge clk) disable iff (rst)
        idle |-> !out_wr_en
    );

endmodule

// ==== hw/lz_dictionary.sv ====
//////////////////////////////////////////////////////////////////////
// Match table with parallel search, highest matching index wins
// Entries persist across jobs, only reset restores the seed contents
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lz_dictionary
    import comp_pkg::*;
#(
    parameter logic [PATTERN_W-1:0] PATTERN = RESET_PATTERN
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear_ptr,
    input  logic [7:0] lookup_byte,
    output logic       hit,
    output logic [3:0] hit_offset,
    input  logic       insert
);

    logic [7:0] entry [DICT_DEPTH];
    logic [3:0] ins_ptr;             // Next slot to replace

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DICT_DEPTH; i++) begin
                entry[i] <= PATTERN[15:8] ^ 8'(i);
            end
            ins_ptr <= '0;
        end else if (clear_ptr) begin
            ins_ptr <= '0;
        end else if (insert) begin
            entry[ins_ptr] <= lookup_byte;
            ins_ptr        <= ins_ptr + 4'd1;   // Wraps 15 to 0
        end
    end

    // Later matches override earlier ones
    always_comb begin
        hit        = 1'b0;
        hit_offset = '0;
        for (int i = 0; i < DICT_DEPTH; i++) begin
            if (entry[i] == lookup_byte) begin
                hit        = 1'b1;
                hit_offset = 4'(i);
            end
        end
    end

    // The engine inserts only on a miss, so a duplicate entry means a
    // broken handshake between engine and table
    a_no_insert_on_hit: assert property (
        @(posedge clk) disable iff (rst)
        !(insert && hit)
    );

endmodule

// ==== hw/byte_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// Byte store with one synchronous write and a combinational read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module byte_buffer
    import comp_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  logic [BUF_ADDR_W-1:0] wr_addr,
    input  logic [7:0]            wr_data,
    input  logic [BUF_ADDR_W-1:0] rd_addr,
    output logic [7:0]            rd_data
);

    logic [7:0] mem [BUF_DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr];   // Read through, no latency

    // A floating address would silently corrupt some entry
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_addr)
    );

endmodule

// ==== hw/host_if_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Host side request and result records
//////////////////////////////////////////////////////////////////////
package host_if_pkg;

    // One byte offered to the input store
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } load_req_t;

    // Result of the last job, held until the next start
    typedef struct packed {
        logic                       done;       // One cycle pulse
        logic                       overflow;   // More than 32 bytes produced
        logic [comp_pkg::LEN_W-1:0] out_len;    // Saturates at 63
        logic [7:0]                 first_byte;
    } comp_result_t;

endpackage

// ==== hw/comp_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Sizes and encodings shared by the compression datapath
// Counts are LEN_W wide so a full 32 byte buffer fits
//////////////////////////////////////////////////////////////////////
package comp_pkg;

    // Job modes as selected by the host
    typedef enum logic [1:0] {
        MODE_RLE      = 2'd0,
        MODE_DICT     = 2'd1,
        MODE_SHORT    = 2'd2,
        MODE_SCRAMBLE = 2'd3
    } comp_mode_e;

    // Engine FSM
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_ANALYZE  = 2'd1,
        ST_COMPRESS = 2'd2,
        ST_REPORT   = 2'd3
    } engine_state_e;

    localparam int BUF_DEPTH  = 32;   // Entries per byte buffer
    localparam int BUF_ADDR_W = 5;
    localparam int DICT_DEPTH = 16;   // Dictionary entries
    localparam int LEN_W      = 6;    // All byte counts

    // Seeds both the dictionary and the scrambler
    localparam int PATTERN_W = 56;
    localparam logic [PATTERN_W-1:0] RESET_PATTERN = 56'h12_3456_789A_BCDE;

endpackage
